// ==== core_pkg.sv ====
package core_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Data and address width, one word
  localparam int unsigned XLEN      = 32;
  // Register file addressing
  localparam int unsigned RF_ADDR_W = 5;
  localparam int unsigned NUM_REGS  = 32;

  ////////////////////////////////////////////////////////////
  // Instruction encodings
  ////////////////////////////////////////////////////////////

  // Major opcodes of the kept instructions
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  // funct3 codes, shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  // Word store
  localparam logic [2:0] F3_SW  = 3'b010;

  // ADDI x0,x0,0
  localparam logic [XLEN-1:0] INSTR_NOP = 32'h0000_0013;

  // All four byte lanes
  localparam logic [3:0] DATA_BE_FULL = 4'b1111;

  // ALU operation select
  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_XOR    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_AND    = 3'd4,
    ALU_PASS_B = 3'd5
  } alu_op_e;

endpackage

// ==== fetch_stage.sv ====
`timescale 1ns/10ps

module fetch_stage import core_pkg::*; (
  input  logic            clk,
  input  logic            rst_ni,
  input  logic [XLEN-1:0] boot_addr_i,
  input  logic            fetch_enable_i,
  // Instruction bus
  output logic            instr_req_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  output logic [XLEN-1:0] instr_addr_o,
  input  logic [XLEN-1:0] instr_rdata_i,
  // Buffer towards execute
  output logic            instr_valid_o,
  output logic [XLEN-1:0] instr_word_o,
  input  logic            instr_taken_i
);

  logic            fetch_en_q;
  logic [XLEN-1:0] pc_q;
  // One request granted, response pending
  logic            outstanding_q;
  logic            buf_valid_q;
  logic [XLEN-1:0] buf_word_q;

  ////////////////////////////////////////////////////////////
  // Request generation
  ////////////////////////////////////////////////////////////

  // Buffer free now or freed this cycle
  // Condition holds steady until grant
  assign instr_req_o  = fetch_en_q && !outstanding_q && (!buf_valid_q || instr_taken_i);
  assign instr_addr_o = pc_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_en_q    <= 1'b0;
      pc_q          <= '0;
      outstanding_q <= 1'b0;
    end else begin
      // Sticky start
      if (fetch_enable_i) begin
        fetch_en_q <= 1'b1;
      end
      // Track boot address until started
      if (!fetch_en_q) begin
        pc_q <= boot_addr_i;
      end else if (instr_req_o && instr_gnt_i) begin
        pc_q <= pc_q + XLEN'(4);
      end
      // Outstanding until the response
      if (instr_req_o && instr_gnt_i) begin
        outstanding_q <= 1'b1;
      end else if (instr_rvalid_i) begin
        outstanding_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // One-entry instruction buffer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      buf_valid_q <= 1'b0;
      buf_word_q  <= INSTR_NOP;
    end else if (instr_rvalid_i) begin
      buf_valid_q <= 1'b1;
      buf_word_q  <= instr_rdata_i;
    end else if (instr_taken_i) begin
      buf_valid_q <= 1'b0;
    end
  end

  assign instr_valid_o = buf_valid_q;
  assign instr_word_o  = buf_word_q;

endmodule

// ==== decoder.sv ====
`timescale 1ns/10ps

module decoder import core_pkg::*; (
  input  logic [XLEN-1:0]      instr_i,
  output logic [RF_ADDR_W-1:0] rs1_addr_o,
  output logic [RF_ADDR_W-1:0] rs2_addr_o,
  output logic [RF_ADDR_W-1:0] rd_addr_o,
  output logic [XLEN-1:0]      imm_o,
  output alu_op_e              alu_op_o,
  output logic                 use_imm_o,
  output logic                 rf_we_o,
  output logic                 store_o
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [XLEN-1:0] imm_i_type;
  logic [XLEN-1:0] imm_s_type;
  logic [XLEN-1:0] imm_u_type;
  // funct7 without the SUB bit
  logic            f7_rest_zero;

  // Fixed field positions
  assign opcode     = instr_i[6:0];
  assign funct3     = instr_i[14:12];
  assign rd_addr_o  = instr_i[11:7];
  assign rs1_addr_o = instr_i[19:15];
  assign rs2_addr_o = instr_i[24:20];

  // Sign-extended immediates
  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_u_type = {instr_i[31:12], 12'b0};

  assign f7_rest_zero = !instr_i[31] && (instr_i[29:25] == 5'b0);

  always_comb begin
    // Unknown encodings retire as no-op
    imm_o     = imm_i_type;
    alu_op_o  = ALU_ADD;
    use_imm_o = 1'b1;
    rf_we_o   = 1'b0;
    store_o   = 1'b0;
    unique case (opcode)
      OPC_OP_IMM: begin
        rf_we_o = 1'b1;
        unique case (funct3)
          F3_ADD:  alu_op_o = ALU_ADD;
          F3_XOR:  alu_op_o = ALU_XOR;
          F3_OR:   alu_op_o = ALU_OR;
          F3_AND:  alu_op_o = ALU_AND;
          default: rf_we_o  = 1'b0;
        endcase
      end
      OPC_OP: begin
        use_imm_o = 1'b0;
        // SUB only via instr[30] on funct3 000
        rf_we_o   = f7_rest_zero && (!instr_i[30] || funct3 == F3_ADD);
        unique case (funct3)
          F3_ADD:  alu_op_o = instr_i[30] ? ALU_SUB : ALU_ADD;
          F3_XOR:  alu_op_o = ALU_XOR;
          F3_OR:   alu_op_o = ALU_OR;
          F3_AND:  alu_op_o = ALU_AND;
          default: rf_we_o  = 1'b0;
        endcase
      end
      OPC_LUI: begin
        imm_o    = imm_u_type;
        alu_op_o = ALU_PASS_B;
        rf_we_o  = 1'b1;
      end
      OPC_STORE: begin
        // Address is rs1 plus S immediate
        imm_o   = imm_s_type;
        store_o = (funct3 == F3_SW);
      end
      default: ;
    endcase
  end

endmodule

// ==== register_file.sv ====
`timescale 1ns/10ps

module register_file import core_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_ni,
  input  logic [RF_ADDR_W-1:0] raddr_a_i,
  input  logic [RF_ADDR_W-1:0] raddr_b_i,
  input  logic [RF_ADDR_W-1:0] waddr_i,
  output logic [XLEN-1:0]      rdata_a_o,
  output logic [XLEN-1:0]      rdata_b_o,
  input  logic                 we_i,
  input  logic [XLEN-1:0]      wdata_i
);

  logic [XLEN-1:0] regs_q [NUM_REGS];

  // x0 keeps its reset value
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Combinational reads
  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

// ==== ex_stage.sv ====
`timescale 1ns/10ps

module ex_stage import core_pkg::*; (
  input  logic            clk,
  input  logic            rst_ni,
  // From fetch buffer
  input  logic            instr_valid_i,
  input  logic [XLEN-1:0] instr_word_i,
  output logic            instr_taken_o,
  // Data bus, stores only
  output logic            data_req_o,
  input  logic            data_gnt_i,
  output logic            data_we_o,
  output logic [3:0]      data_be_o,
  output logic [XLEN-1:0] data_addr_o,
  output logic [XLEN-1:0] data_wdata_o
);

  logic [RF_ADDR_W-1:0] rs1_addr;
  logic [RF_ADDR_W-1:0] rs2_addr;
  logic [RF_ADDR_W-1:0] rd_addr;
  logic [XLEN-1:0]      imm;
  alu_op_e              alu_op;
  logic                 use_imm;
  logic                 rf_we;
  logic                 store;
  logic [XLEN-1:0]      rs1_data;
  logic [XLEN-1:0]      rs2_data;
  logic [XLEN-1:0]      operand_b;
  logic [XLEN-1:0]      alu_result;

  decoder decoder_i (
    .instr_i    ( instr_word_i ),
    .rs1_addr_o ( rs1_addr     ),
    .rs2_addr_o ( rs2_addr     ),
    .rd_addr_o  ( rd_addr      ),
    .imm_o      ( imm          ),
    .alu_op_o   ( alu_op       ),
    .use_imm_o  ( use_imm      ),
    .rf_we_o    ( rf_we        ),
    .store_o    ( store        )
  );

  // Write lands at the edge after retirement
  register_file register_file_i (
    .clk       ( clk                    ),
    .rst_ni    ( rst_ni                 ),
    .raddr_a_i ( rs1_addr               ),
    .raddr_b_i ( rs2_addr               ),
    .waddr_i   ( rd_addr                ),
    .rdata_a_o ( rs1_data               ),
    .rdata_b_o ( rs2_data               ),
    .we_i      ( instr_taken_o && rf_we ),
    .wdata_i   ( alu_result             )
  );

  ////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////

  assign operand_b = use_imm ? imm : rs2_data;

  always_comb begin
    unique case (alu_op)
      ALU_SUB:    alu_result = rs1_data - operand_b;
      ALU_XOR:    alu_result = rs1_data ^ operand_b;
      ALU_OR:     alu_result = rs1_data | operand_b;
      ALU_AND:    alu_result = rs1_data & operand_b;
      ALU_PASS_B: alu_result = operand_b;
      default:    alu_result = rs1_data + operand_b;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Store request and retirement
  ////////////////////////////////////////////////////////////

  // Buffer holds the word, so request is steady until grant
  assign data_req_o    = instr_valid_i && store;
  assign data_we_o     = store;
  assign data_be_o     = DATA_BE_FULL;
  assign data_addr_o   = alu_result;
  assign data_wdata_o  = rs2_data;

  // Store stalls for grant
  assign instr_taken_o = instr_valid_i && (!store || data_gnt_i);

endmodule

// ==== mini_rv_core.sv ====
`timescale 1ns/10ps

module mini_rv_core import core_pkg::*; (
  input  logic            clk,
  input  logic            rst_ni,
  input  logic [XLEN-1:0] boot_addr_i,
  input  logic            fetch_enable_i,
  // Instruction bus
  output logic            instr_req_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  output logic [XLEN-1:0] instr_addr_o,
  input  logic [XLEN-1:0] instr_rdata_i,
  // Data bus
  output logic            data_req_o,
  input  logic            data_gnt_i,
  output logic            data_we_o,
  output logic [3:0]      data_be_o,
  output logic [XLEN-1:0] data_addr_o,
  output logic [XLEN-1:0] data_wdata_o
);

  // Fetch to execute
  logic            instr_valid;
  logic [XLEN-1:0] instr_word;
  logic            instr_taken;

  ////////////////////////////////////////////////////////////
  // Fetch
  ////////////////////////////////////////////////////////////

  fetch_stage fetch_stage_i (
    .clk            ( clk            ),
    .rst_ni         ( rst_ni         ),
    .boot_addr_i    ( boot_addr_i    ),
    .fetch_enable_i ( fetch_enable_i ),
    .instr_req_o    ( instr_req_o    ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .instr_valid_o  ( instr_valid    ),
    .instr_word_o   ( instr_word     ),
    .instr_taken_i  ( instr_taken    )
  );

  ////////////////////////////////////////////////////////////
  // Decode and execute
  ////////////////////////////////////////////////////////////

  ex_stage ex_stage_i (
    .clk           ( clk          ),
    .rst_ni        ( rst_ni       ),
    .instr_valid_i ( instr_valid  ),
    .instr_word_i  ( instr_word   ),
    .instr_taken_o ( instr_taken  ),
    .data_req_o    ( data_req_o   ),
    .data_gnt_i    ( data_gnt_i   ),
    .data_we_o     ( data_we_o    ),
    .data_be_o     ( data_be_o    ),
    .data_addr_o   ( data_addr_o  ),
    .data_wdata_o  ( data_wdata_o )
  );

endmodule

// ==== core_checker.sv ====
`timescale 1ns/10ps

module core_checker import core_pkg::*; (
  input logic            clk,
  input logic            rst_ni,
  input logic            instr_req_o,
  input logic            instr_gnt_i,
  input logic [XLEN-1:0] instr_addr_o,
  input logic            data_req_o,
  input logic            data_gnt_i,
  input logic            data_we_o,
  input logic [XLEN-1:0] data_addr_o,
  input logic [XLEN-1:0] data_wdata_o
);

  ////////////////////////////////////////////////////////////
  // Bus protocol rules
  ////////////////////////////////////////////////////////////

  // Ungranted request holds with a steady address
  instr_hold_a: assert property (@(posedge clk) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("instruction request dropped or moved before grant");

  data_hold_a: assert property (@(posedge clk) disable iff (!rst_ni)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o) && $stable(data_wdata_o))
    else $error("data request dropped or moved before grant");

  // Only stores exist
  data_we_a: assert property (@(posedge clk) disable iff (!rst_ni)
    data_req_o |-> data_we_o)
    else $error("data request without write enable");

  // Quiet bus in reset
  reset_quiet_a: assert property (@(posedge clk)
    !rst_ni |-> !instr_req_o && !data_req_o)
    else $error("bus request during reset");

endmodule

// ==== tb_core.sv ====
`timescale 1ns/10ps

module tb_core import core_pkg::*; ();

  localparam int          CLK_HALF   = 50;
  localparam int          DRIVE_DLY  = 1;
  localparam int          IMEM_WORDS = 256;
  localparam int          RAND_OPS   = 24;
  localparam int          TIMEOUT    = 5000;
  localparam logic [31:0] BOOT_ADDR  = 32'h0000_1000;
  localparam logic [31:0] LCG_SEED   = 32'hcd94_1612;

  logic            clk = 1'b0;
  logic            rst_ni;
  logic [XLEN-1:0] boot_addr_i;
  logic            fetch_enable_i;
  logic            instr_req_o;
  logic            instr_gnt_i;
  logic            instr_rvalid_i;
  logic [XLEN-1:0] instr_addr_o;
  logic [XLEN-1:0] instr_rdata_i;
  logic            data_req_o;
  logic            data_gnt_i;
  logic            data_we_o;
  logic [3:0]      data_be_o;
  logic [XLEN-1:0] data_addr_o;
  logic [XLEN-1:0] data_wdata_o;

  // Program image and expected stores
  logic [31:0] imem [IMEM_WORDS];
  int          prog_tag [IMEM_WORDS];
  int          prog_len;
  logic [11:0] sw_addr;
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  int          exp_tag [$];
  // Bus logs
  logic [31:0] fetch_log [$];
  logic [31:0] st_addr_q [$];
  logic [31:0] st_data_q [$];
  logic [3:0]  st_be_q [$];
  // Bookkeeping
  logic [31:0] lcg_state;
  int          chk_idx;
  int          test_err [7];
  int          tests_run;
  int          tests_failed;
  int          extra_err;
  string       test_name [7];

  mini_rv_core dut0 (.*);

  bind mini_rv_core core_checker checker0 (
    .clk            ( clk            ),
    .rst_ni         ( rst_ni         ),
    .instr_req_o    ( instr_req_o    ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_addr_o   ( instr_addr_o   ),
    .data_req_o     ( data_req_o     ),
    .data_gnt_i     ( data_gnt_i     ),
    .data_we_o      ( data_we_o      ),
    .data_addr_o    ( data_addr_o    ),
    .data_wdata_o   ( data_wdata_o   )
  );

  always #(CLK_HALF) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Random numbers and instruction encoding
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] rand_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    // Drop the weak low bits
    return lcg_state >> 12;
  endfunction

  function automatic logic [31:0] enc_i(logic [2:0] f3, int rd, int rs1, logic [11:0] imm);
    return {imm, 5'(rs1), f3, 5'(rd), OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] enc_r(logic sub, logic [2:0] f3, int rd, int rs1, int rs2);
    return {1'b0, sub, 5'b0, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
  endfunction

  function automatic logic [31:0] enc_u(int rd, logic [19:0] imm);
    return {imm, 5'(rd), OPC_LUI};
  endfunction

  task automatic emit(input logic [31:0] word, input int tag);
    imem[prog_len]     = word;
    prog_tag[prog_len] = tag;
    prog_len++;
  endtask

  // SW rs2 to the next free slot, base x0
  task automatic emit_sw(input int rs2, input int tag);
    emit({sw_addr[11:5], 5'(rs2), 5'd0, F3_SW, sw_addr[4:0], OPC_STORE}, tag);
    sw_addr = sw_addr + 12'd4;
  endtask

  task automatic build_program();
    logic [31:0] r;
    int          rd;
    int          rs1;
    int          rs2;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = INSTR_NOP;
    end
    prog_len = 0;
    sw_addr  = 12'h400;
    // Immediate ops
    emit(enc_i(F3_ADD, 1, 0, 12'h123), 2);
    emit(enc_i(F3_XOR, 2, 1, 12'hfff), 2);
    emit(enc_i(F3_OR, 3, 1, 12'h7f0), 2);
    emit(enc_i(F3_AND, 4, 2, 12'h0f0), 2);
    emit(enc_u(5, 20'habcde), 2);
    emit(enc_i(F3_ADD, 5, 5, 12'hfee), 2);
    for (int i = 1; i <= 5; i++) begin
      emit_sw(i, 2);
    end
    // Register ops, each reading the previous result
    emit(enc_r(1'b0, F3_ADD, 6, 1, 5), 3);
    emit(enc_r(1'b1, F3_ADD, 7, 6, 2), 3);
    emit(enc_r(1'b0, F3_XOR, 8, 7, 3), 3);
    emit(enc_r(1'b0, F3_OR, 9, 8, 4), 3);
    emit(enc_r(1'b0, F3_AND, 10, 9, 5), 3);
    for (int i = 6; i <= 10; i++) begin
      emit_sw(i, 3);
    end
    // x0 stays zero
    emit(enc_i(F3_ADD, 0, 1, 12'h005), 4);
    emit(enc_r(1'b0, F3_ADD, 0, 1, 2), 4);
    emit_sw(0, 4);
    // Random mix
    for (int i = 0; i < RAND_OPS; i++) begin
      rd  = int'(rand_next() % 32);
      rs1 = int'(rand_next() % 32);
      rs2 = int'(rand_next() % 32);
      r   = rand_next();
      case (rand_next() % 10)
        0: emit(enc_i(F3_ADD, rd, rs1, r[11:0]), 5);
        1: emit(enc_i(F3_XOR, rd, rs1, r[11:0]), 5);
        2: emit(enc_i(F3_OR, rd, rs1, r[11:0]), 5);
        3: emit(enc_i(F3_AND, rd, rs1, r[11:0]), 5);
        4: emit(enc_u(rd, r[19:0]), 5);
        5: emit(enc_r(1'b0, F3_ADD, rd, rs1, rs2), 5);
        6: emit(enc_r(1'b1, F3_ADD, rd, rs1, rs2), 5);
        7: emit(enc_r(1'b0, F3_XOR, rd, rs1, rs2), 5);
        8: emit(enc_r(1'b0, F3_OR, rd, rs1, rs2), 5);
        default: emit(enc_r(1'b0, F3_AND, rd, rs1, rs2), 5);
      endcase
      if (i % 3 == 2) begin
        emit_sw(int'(rand_next() % 32), 5);
      end
    end
    // Dump the whole register file
    for (int i = 1; i < 32; i++) begin
      emit_sw(i, 5);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Runs the image straight through, RV32I semantics
  function automatic void ref_run();
    logic [31:0] regs [32];
    logic [31:0] w;
    logic [31:0] res;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic        we;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < prog_len; i++) begin
      w     = imem[i];
      imm_i = {{20{w[31]}}, w[31:20]};
      imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
      we    = 1'b1;
      res   = '0;
      case (w[6:0])
        OPC_OP_IMM: begin
          case (w[14:12])
            F3_ADD:  res = regs[w[19:15]] + imm_i;
            F3_XOR:  res = regs[w[19:15]] ^ imm_i;
            F3_OR:   res = regs[w[19:15]] | imm_i;
            F3_AND:  res = regs[w[19:15]] & imm_i;
            default: we  = 1'b0;
          endcase
        end
        OPC_OP: begin
          case (w[14:12])
            F3_ADD:  res = w[30] ? regs[w[19:15]] - regs[w[24:20]]
                                 : regs[w[19:15]] + regs[w[24:20]];
            F3_XOR:  res = regs[w[19:15]] ^ regs[w[24:20]];
            F3_OR:   res = regs[w[19:15]] | regs[w[24:20]];
            F3_AND:  res = regs[w[19:15]] & regs[w[24:20]];
            default: we  = 1'b0;
          endcase
        end
        OPC_LUI: res = {w[31:12], 12'b0};
        OPC_STORE: begin
          we = 1'b0;
          exp_addr.push_back(regs[w[19:15]] + imm_s);
          exp_data.push_back(regs[w[24:20]]);
          exp_tag.push_back(prog_tag[i]);
        end
        default: we = 1'b0;
      endcase
      if (we && w[11:7] != 5'd0) begin
        regs[w[11:7]] = res;
      end
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // Bus models
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] imem_read(logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - BOOT_ADDR) >> 2;
    if (idx < IMEM_WORDS) begin
      return imem[idx[7:0]];
    end
    return INSTR_NOP;
  endfunction

  // Sample at negedge, drive after the next rising edge
  always begin : bus_models
    int          ign_cnt;
    int          irv_cnt;
    int          dgn_cnt;
    logic        ign_n;
    logic        irv_n;
    logic        dgn_n;
    logic [31:0] irdata_n;
    @(negedge clk);
    if (!rst_ni) begin
      ign_n    = 1'b0;
      irv_n    = 1'b0;
      dgn_n    = 1'b0;
      irdata_n = '0;
      irv_cnt  = 0;
      ign_cnt  = int'(rand_next() % 4);
      dgn_cnt  = int'(rand_next() % 4);
    end else begin
      // Grant delay counts only cycles with a pending request
      if (instr_req_o && instr_gnt_i) begin
        fetch_log.push_back(instr_addr_o);
        irdata_n = imem_read(instr_addr_o);
        irv_cnt  = 1 + int'(rand_next() % 2);
        ign_cnt  = int'(rand_next() % 4);
      end else if (instr_req_o && ign_cnt > 0) begin
        ign_cnt--;
      end
      irv_n = (irv_cnt == 1);
      if (irv_cnt > 0) begin
        irv_cnt--;
      end
      ign_n = (ign_cnt == 0);
      if (data_req_o && data_gnt_i) begin
        st_addr_q.push_back(data_addr_o);
        st_data_q.push_back(data_wdata_o);
        st_be_q.push_back(data_be_o);
        dgn_cnt = int'(rand_next() % 4);
      end else if (data_req_o && dgn_cnt > 0) begin
        dgn_cnt--;
      end
      dgn_n = (dgn_cnt == 0);
    end
    @(posedge clk);
    #(DRIVE_DLY);
    instr_gnt_i    = ign_n;
    instr_rvalid_i = irv_n;
    instr_rdata_i  = irdata_n;
    data_gnt_i     = dgn_n;
  end

  ////////////////////////////////////////////////////////////
  // Compare and report
  ////////////////////////////////////////////////////////////

  task automatic report_test(input int t);
    tests_run++;
    if (test_err[t] != 0) begin
      tests_failed++;
      $display("Test %0d %s: FAIL, %0d errors", t, test_name[t], test_err[t]);
    end else begin
      $display("Test %0d %s: ok", t, test_name[t]);
    end
  endtask

  always @(posedge clk) begin : compare
    logic [31:0] a;
    logic [31:0] d;
    logic [3:0]  be;
    int          tag;
    while (st_addr_q.size() > 0) begin
      a  = st_addr_q.pop_front();
      d  = st_data_q.pop_front();
      be = st_be_q.pop_front();
      if (chk_idx >= exp_addr.size()) begin
        $display("Store beyond the expected list: addr %h data %h", a, d);
        extra_err++;
      end else begin
        tag = exp_tag[chk_idx];
        if (a !== exp_addr[chk_idx]) begin
          $display("mismatch data_addr_o #%0d: got %h exp %h", chk_idx, a, exp_addr[chk_idx]);
          test_err[tag]++;
        end
        if (d !== exp_data[chk_idx]) begin
          $display("mismatch data_wdata_o #%0d: got %h exp %h", chk_idx, d, exp_data[chk_idx]);
          test_err[tag]++;
        end
        if (be !== DATA_BE_FULL) begin
          $display("mismatch data_be_o #%0d: got %h exp %h", chk_idx, be, DATA_BE_FULL);
          test_err[tag]++;
        end
        // Last store of its group closes the test
        if (chk_idx == exp_addr.size() - 1 || exp_tag[chk_idx + 1] != tag) begin
          report_test(tag);
        end
        chk_idx++;
      end
    end
  end

  initial begin : main
    int cyc;
    rst_ni         = 1'b0;
    boot_addr_i    = BOOT_ADDR;
    fetch_enable_i = 1'b0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    data_gnt_i     = 1'b0;
    lcg_state      = LCG_SEED;
    chk_idx        = 0;
    tests_run      = 0;
    tests_failed   = 0;
    extra_err      = 0;
    test_name      = '{"", "reset and boot", "immediate ops", "register ops",
                       "x0 writes", "random stores", "fetch order"};
    for (int t = 0; t < 7; t++) begin
      test_err[t] = 0;
    end
    build_program();
    ref_run();

    // Reset, then a few idle cycles before enable
    for (int i = 0; i < 7; i++) begin
      @(negedge clk);
      if (instr_req_o || data_req_o) begin
        $display("Bus request raised before fetch enable, cycle %0d", i);
        test_err[1]++;
      end
      @(posedge clk);
      if (i == 3) begin
        #(DRIVE_DLY) rst_ni = 1'b1;
      end
    end
    // Single-cycle pulse, start is sticky
    #(DRIVE_DLY) fetch_enable_i = 1'b1;
    @(posedge clk);
    #(DRIVE_DLY) fetch_enable_i = 1'b0;

    cyc = 0;
    while (chk_idx < exp_addr.size() && cyc < TIMEOUT) begin
      @(negedge clk);
      cyc++;
    end
    if (chk_idx < exp_addr.size()) begin
      $display("Timeout: only %0d of %0d stores seen", chk_idx, exp_addr.size());
      $display("Simulation failed");
      $finish;
    end else begin
      // Quiet tail to catch stray stores
      repeat (20) @(negedge clk);
      if (fetch_log.size() == 0) begin
        $display("No instruction fetch was granted");
        test_err[1]++;
      end else if (fetch_log[0] !== BOOT_ADDR) begin
        $display("mismatch instr_addr_o first fetch: got %h exp %h", fetch_log[0],
                 BOOT_ADDR);
        test_err[1]++;
      end
      report_test(1);
      for (int i = 0; i < fetch_log.size(); i++) begin
        if (fetch_log[i] !== BOOT_ADDR + 32'(4 * i)) begin
          $display("mismatch instr_addr_o #%0d: got %h exp %h", i, fetch_log[i],
                   BOOT_ADDR + 32'(4 * i));
          test_err[6]++;
        end
      end
      report_test(6);
      $display("Tests run %0d, failed %0d, stray stores %0d", tests_run, tests_failed,
               extra_err);
      if (tests_failed == 0 && extra_err == 0 && tests_run == 6) begin
        $display("Simulation completed successfully");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

endmodule

// ==== tb.f ====
core_pkg.sv
fetch_stage.sv
decoder.sv
register_file.sv
ex_stage.sv
mini_rv_core.sv
core_checker.sv
tb_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_core
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
